// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define DATA_W     16
`define REG_IDX_W  3
`define REG_COUNT  8

// opcode occupies instr[15:11]
`define OPC_LSB    11

`endif

// File: isa_pkg.sv
`include "cpu_config.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0]    data_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [4:0]            imm5_t;
    typedef logic [7:0]            imm8_t;

    typedef enum logic [`DATA_W-`OPC_LSB-1:0] {
        OPC_HALT = 5'b00000,
        OPC_NOP  = 5'b00001,
        OPC_JR   = 5'b00101,
        OPC_ADDI = 5'b01000,
        OPC_BEQZ = 5'b01100,
        OPC_BNEZ = 5'b01101,
        OPC_ST   = 5'b10000,
        OPC_LD   = 5'b10001,
        OPC_ADD  = 5'b11000,
        OPC_SUB  = 5'b11001,
        OPC_AND  = 5'b11010,
        OPC_XOR  = 5'b11011,
        OPC_SEQ  = 5'b11100,
        OPC_SLT  = 5'b11101
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_AND    = 3'd1,
        ALU_XOR    = 3'd2,
        ALU_PASS_B = 3'd3
    } alu_op_t;

    typedef enum logic [1:0] {BR_NONE, BR_EQZ, BR_NEZ} br_cnd_t;
    typedef enum logic [1:0] {SET_NONE, SET_LT, SET_EQ} set_sel_t;
    typedef enum logic [1:0] {WR_ALU, WR_SET, WR_LINK} wr_sel_t;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

    // decoded instruction as held between decode and execute
    typedef struct packed {
        isa_pkg::data_t    pc_inc;
        isa_pkg::data_t    rd_data_1;
        isa_pkg::data_t    rd_data_2;
        isa_pkg::data_t    sext_imm;
        isa_pkg::reg_idx_t rd_reg_1;
        isa_pkg::reg_idx_t wr_reg;
        logic              use_imm;    // operand b from immediate
        isa_pkg::alu_op_t  alu_op;
        logic              alu_inv_a;
        logic              alu_inv_b;
        logic              alu_cin;
        logic              alu_sign;   // signed compare for slt
        isa_pkg::br_cnd_t  br_cnd;
        isa_pkg::set_sel_t set_sel;
        isa_pkg::wr_sel_t  wr_sel;
        logic              wr_en;
        logic              mem_en;
        logic              mem_wr;
        logic              jmp_reg_instr;
        logic              br_instr;
        logic              halt;
    } id_ex_t;

    typedef struct packed {
        isa_pkg::data_t    value;      // writeback word, also mem address
        isa_pkg::data_t    store_data;
        isa_pkg::data_t    br_target;
        logic              br_taken;
        isa_pkg::reg_idx_t wr_reg;
        logic              wr_en;
        logic              mem_en;
        logic              mem_wr;
        logic              halt;
    } ex_res_t;

endpackage

// File: reg_file.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  isa_pkg::reg_idx_t rd_idx_1,
    input  isa_pkg::reg_idx_t rd_idx_2,
    output isa_pkg::data_t    rd_data_1,
    output isa_pkg::data_t    rd_data_2,
    input  logic              wr_en,
    input  isa_pkg::reg_idx_t wr_idx,
    input  isa_pkg::data_t    wr_data
);

    isa_pkg::data_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through so decode sees the value being written
    assign rd_data_1 = (wr_en && (wr_idx == rd_idx_1)) ? wr_data : regs[rd_idx_1];
    assign rd_data_2 = (wr_en && (wr_idx == rd_idx_2)) ? wr_data : regs[rd_idx_2];

endmodule

// File: instr_decode.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module instr_decode (
    input  isa_pkg::data_t    instr,
    input  logic              instr_valid,
    input  isa_pkg::data_t    pc_inc,
    output isa_pkg::reg_idx_t rd_idx_1,
    output isa_pkg::reg_idx_t rd_idx_2,
    input  isa_pkg::data_t    rd_data_1,
    input  isa_pkg::data_t    rd_data_2,
    output pipe_pkg::id_ex_t  dec
);

    isa_pkg::opcode_t  opc;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t rd;
    isa_pkg::imm5_t    imm5;
    isa_pkg::imm8_t    imm8;

    assign opc  = isa_pkg::opcode_t'(instr[`DATA_W-1:`OPC_LSB]);
    assign rs   = instr[10:8];
    assign rt   = instr[7:5];
    assign rd   = instr[4:2];
    assign imm5 = instr[4:0];
    assign imm8 = instr[7:0];

    assign rd_idx_1 = rs;
    assign rd_idx_2 = rt;

    always_comb begin
        dec           = '0;                 // nop unless decoded below
        dec.pc_inc    = pc_inc;
        dec.rd_data_1 = rd_data_1;
        dec.rd_data_2 = rd_data_2;
        dec.rd_reg_1  = rs;
        dec.wr_reg    = rd;
        dec.alu_op    = isa_pkg::ALU_PASS_B;
        dec.sext_imm  = {{(`DATA_W-5){imm5[4]}}, imm5};
        if (instr_valid) begin
            case (opc)
                isa_pkg::OPC_ADD: begin
                    dec.alu_op = isa_pkg::ALU_ADD;
                    dec.wr_en  = 1'b1;
                end
                isa_pkg::OPC_SUB: begin
                    dec.alu_op    = isa_pkg::ALU_ADD;
                    dec.alu_inv_b = 1'b1;           // rs + ~rt + 1
                    dec.alu_cin   = 1'b1;
                    dec.wr_en     = 1'b1;
                end
                isa_pkg::OPC_AND: begin
                    dec.alu_op = isa_pkg::ALU_AND;
                    dec.wr_en  = 1'b1;
                end
                isa_pkg::OPC_XOR: begin
                    dec.alu_op = isa_pkg::ALU_XOR;
                    dec.wr_en  = 1'b1;
                end
                isa_pkg::OPC_ADDI: begin
                    dec.alu_op  = isa_pkg::ALU_ADD;
                    dec.use_imm = 1'b1;
                    dec.wr_reg  = rt;
                    dec.wr_en   = 1'b1;
                end
                isa_pkg::OPC_SLT, isa_pkg::OPC_SEQ: begin
                    dec.alu_op    = isa_pkg::ALU_ADD;
                    dec.alu_inv_b = 1'b1;
                    dec.alu_cin   = 1'b1;
                    dec.alu_sign  = 1'b1;
                    dec.set_sel   = (opc == isa_pkg::OPC_SLT) ? isa_pkg::SET_LT : isa_pkg::SET_EQ;
                    dec.wr_sel    = isa_pkg::WR_SET;
                    dec.wr_en     = 1'b1;
                end
                isa_pkg::OPC_LD, isa_pkg::OPC_ST: begin
                    dec.alu_op  = isa_pkg::ALU_ADD;  // address = rs + imm5
                    dec.use_imm = 1'b1;
                    dec.wr_reg  = rt;
                    dec.mem_en  = 1'b1;
                    dec.mem_wr  = (opc == isa_pkg::OPC_ST);
                end
                isa_pkg::OPC_BEQZ, isa_pkg::OPC_BNEZ: begin
                    dec.sext_imm = {{(`DATA_W-8){imm8[7]}}, imm8};
                    dec.br_cnd   = (opc == isa_pkg::OPC_BEQZ) ? isa_pkg::BR_EQZ : isa_pkg::BR_NEZ;
                    dec.br_instr = 1'b1;
                end
                isa_pkg::OPC_JR:   dec.jmp_reg_instr = 1'b1;
                isa_pkg::OPC_HALT: dec.halt = 1'b1;
                default: ;                          // nop and unknown opcodes
            endcase
        end
    end

endmodule

// File: id_ex.sv
`timescale 1ns/100ps

module id_ex (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             stall_n,   // low while decode holds
    input  logic             flush,     // taken branch or jump in execute
    input  pipe_pkg::id_ex_t dec,
    output pipe_pkg::id_ex_t ex_in
);

    pipe_pkg::id_ex_t nxt;
    logic             keep;

    assign keep = stall_n & ~flush;

    // bubble: payload passes, side effects are dropped
    always_comb begin
        nxt               = dec;
        nxt.wr_en         = dec.wr_en & keep;
        nxt.mem_en        = dec.mem_en & keep;
        nxt.mem_wr        = dec.mem_wr & keep;
        nxt.jmp_reg_instr = dec.jmp_reg_instr & keep;
        nxt.br_instr      = dec.br_instr & keep;
        nxt.halt          = dec.halt & keep;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_in <= '0;
        end else begin
            ex_in <= nxt;
        end
    end

    a_ctrl_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({ex_in.wr_en, ex_in.mem_en, ex_in.mem_wr,
                     ex_in.jmp_reg_instr, ex_in.br_instr, ex_in.halt}));

endmodule

// File: execute.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module execute (
    input  pipe_pkg::id_ex_t  ex_in,
    output pipe_pkg::ex_res_t ex_out,
    output logic              flush
);

    isa_pkg::data_t opnd_a;
    isa_pkg::data_t opnd_b;
    isa_pkg::data_t alu_a;
    isa_pkg::data_t alu_b;
    isa_pkg::data_t sum;
    isa_pkg::data_t alu_res;
    logic           carry;
    logic           ovf;
    logic           set_lt;
    logic           set_bit;
    logic           cond_ok;

    assign opnd_a = ex_in.rd_data_1;
    assign opnd_b = ex_in.use_imm ? ex_in.sext_imm : ex_in.rd_data_2;
    assign alu_a  = ex_in.alu_inv_a ? ~opnd_a : opnd_a;
    assign alu_b  = ex_in.alu_inv_b ? ~opnd_b : opnd_b;

    assign {carry, sum} = {1'b0, alu_a} + {1'b0, alu_b} + {{`DATA_W{1'b0}}, ex_in.alu_cin};
    assign ovf = (alu_a[`DATA_W-1] == alu_b[`DATA_W-1]) && (sum[`DATA_W-1] != alu_a[`DATA_W-1]);
    assign set_lt = ex_in.alu_sign ? (sum[`DATA_W-1] ^ ovf) : ~carry;

    always_comb begin
        case (ex_in.alu_op)
            isa_pkg::ALU_ADD: alu_res = sum;
            isa_pkg::ALU_AND: alu_res = alu_a & alu_b;
            isa_pkg::ALU_XOR: alu_res = alu_a ^ alu_b;
            default:          alu_res = alu_b;      // pass b
        endcase
        case (ex_in.set_sel)
            isa_pkg::SET_LT: set_bit = set_lt;
            isa_pkg::SET_EQ: set_bit = (sum == '0);
            default:         set_bit = 1'b0;
        endcase
        case (ex_in.br_cnd)
            isa_pkg::BR_EQZ: cond_ok = (opnd_a == '0);
            isa_pkg::BR_NEZ: cond_ok = (opnd_a != '0);
            default:         cond_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_in.wr_sel)
            isa_pkg::WR_SET:  ex_out.value = {{(`DATA_W-1){1'b0}}, set_bit};
            isa_pkg::WR_LINK: ex_out.value = ex_in.pc_inc;
            default:          ex_out.value = alu_res;
        endcase
        ex_out.store_data = ex_in.rd_data_2;
        ex_out.br_target  = ex_in.jmp_reg_instr ? opnd_a : ex_in.pc_inc + ex_in.sext_imm;
        ex_out.br_taken   = (ex_in.br_instr & cond_ok) | ex_in.jmp_reg_instr;
        ex_out.wr_reg     = ex_in.wr_reg;
        ex_out.wr_en      = ex_in.wr_en;
        ex_out.mem_en     = ex_in.mem_en;
        ex_out.mem_wr     = ex_in.mem_wr;
        ex_out.halt       = ex_in.halt;
    end

    assign flush = ex_out.br_taken;

endmodule

// File: result_stage.sv
`timescale 1ns/100ps

module result_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  pipe_pkg::ex_res_t ex_out,
    output logic              wr_en,
    output isa_pkg::reg_idx_t wr_reg,
    output isa_pkg::data_t    wr_data,
    output logic              mem_en,
    output logic              mem_wr,
    output isa_pkg::data_t    mem_addr,
    output isa_pkg::data_t    mem_wdata,
    output logic              redirect,
    output isa_pkg::data_t    redirect_pc,
    output logic              halted
);

    pipe_pkg::ex_res_t res_q;
    logic              live;

    assign live = ~halted;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_q  <= '0;
            halted <= 1'b0;
        end else begin
            res_q          <= ex_out;
            res_q.wr_en    <= ex_out.wr_en & live;     // nothing retires after halt
            res_q.mem_en   <= ex_out.mem_en & live;
            res_q.mem_wr   <= ex_out.mem_wr & live;
            res_q.br_taken <= ex_out.br_taken & live;
            res_q.halt     <= ex_out.halt & live;
            halted         <= halted | ex_out.halt;    // sticky
        end
    end

    assign wr_en       = res_q.wr_en;
    assign wr_reg      = res_q.wr_reg;
    assign wr_data     = res_q.value;
    assign mem_en      = res_q.mem_en;
    assign mem_wr      = res_q.mem_wr;
    assign mem_addr    = res_q.value;
    assign mem_wdata   = res_q.store_data;
    assign redirect    = res_q.br_taken;
    assign redirect_pc = res_q.br_target;

    a_wr_needs_en: assert property (@(posedge clk) disable iff (!arst_n) mem_wr |-> mem_en);

endmodule

// File: exec_core.sv
`timescale 1ns/100ps

module exec_core (
    input  logic              clk,
    input  logic              arst_n,
    input  isa_pkg::data_t    instr,
    input  logic              instr_valid,
    input  isa_pkg::data_t    pc_inc,
    input  logic              stall_n,
    output logic              wr_en,
    output isa_pkg::reg_idx_t wr_reg,
    output isa_pkg::data_t    wr_data,
    output logic              mem_en,
    output logic              mem_wr,
    output isa_pkg::data_t    mem_addr,
    output isa_pkg::data_t    mem_wdata,
    output logic              redirect,
    output isa_pkg::data_t    redirect_pc,
    output logic              halted
);

    isa_pkg::reg_idx_t rd_idx_1;
    isa_pkg::reg_idx_t rd_idx_2;
    isa_pkg::data_t    rd_data_1;
    isa_pkg::data_t    rd_data_2;
    pipe_pkg::id_ex_t  dec;
    pipe_pkg::id_ex_t  ex_in;
    pipe_pkg::ex_res_t ex_out;
    logic              flush;

    reg_file u_reg_file (
        .clk(clk), .arst_n(arst_n),
        .rd_idx_1(rd_idx_1), .rd_idx_2(rd_idx_2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .wr_en(wr_en), .wr_idx(wr_reg), .wr_data(wr_data)
    );

    instr_decode u_instr_decode (
        .instr(instr), .instr_valid(instr_valid), .pc_inc(pc_inc),
        .rd_idx_1(rd_idx_1), .rd_idx_2(rd_idx_2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2), .dec(dec)
    );

    id_ex u_id_ex (
        .clk(clk), .arst_n(arst_n), .stall_n(stall_n), .flush(flush),
        .dec(dec), .ex_in(ex_in)
    );

    execute u_execute (.ex_in(ex_in), .ex_out(ex_out), .flush(flush));

    result_stage u_result_stage (
        .clk(clk), .arst_n(arst_n), .ex_out(ex_out),
        .wr_en(wr_en), .wr_reg(wr_reg), .wr_data(wr_data),
        .mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .redirect(redirect), .redirect_pc(redirect_pc), .halted(halted)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #0.5 arst_n = 1'b1;         // release off the edge
    end

endmodule

// File: tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core;

    typedef struct packed {
        logic              wr_en;
        isa_pkg::reg_idx_t wr_reg;
        isa_pkg::data_t    wr_data;
        logic              mem_en;
        logic              mem_wr;
        isa_pkg::data_t    mem_addr;
        isa_pkg::data_t    mem_wdata;
        logic              redirect;
        isa_pkg::data_t    redirect_pc;
        logic              halted;
    } expect_t;

    localparam int N_RAND = 80;
    localparam int N_MEM  = 20;
    localparam int EST_CYCLES = 40 + 7 * 16 * 3 + (N_RAND + N_MEM) * 3 + 120;
    localparam int WATCHDOG_NS = EST_CYCLES * 4 * 2 + 200;

    logic              clk;
    logic              arst_n;
    isa_pkg::data_t    instr;
    logic              instr_valid;
    isa_pkg::data_t    pc_inc;
    logic              stall_n;
    logic              wr_en;
    isa_pkg::reg_idx_t wr_reg;
    isa_pkg::data_t    wr_data;
    logic              mem_en;
    logic              mem_wr;
    isa_pkg::data_t    mem_addr;
    isa_pkg::data_t    mem_wdata;
    logic              redirect;
    isa_pkg::data_t    redirect_pc;
    logic              halted;

    isa_pkg::data_t ref_regs [8];
    expect_t        cur;
    expect_t        s1;
    expect_t        s2;
    logic           flush_pend;
    logic           model_halted;
    logic [31:0]    rng;
    int             err_cnt;
    int             err_mark;
    int             pass_cnt;
    int             fail_cnt;

    tb_clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

    exec_core u_exec_core (
        .clk(clk), .arst_n(arst_n), .instr(instr), .instr_valid(instr_valid),
        .pc_inc(pc_inc), .stall_n(stall_n), .wr_en(wr_en), .wr_reg(wr_reg),
        .wr_data(wr_data), .mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .redirect(redirect), .redirect_pc(redirect_pc),
        .halted(halted)
    );

    // expectation follows the instruction through id_ex and the result stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1 <= '0;
            s2 <= '0;
        end else begin
            s1 <= cur;
            s2 <= s1;
        end
    end

    task automatic value_error(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        $display("Error: %s = %h, expected %h", name, got, exp);
        err_cnt++;
    endtask

    a_wr_en: assert property (@(posedge clk) disable iff (!arst_n) wr_en == s2.wr_en)
        else value_error("wr_en", 16'($sampled(wr_en)), 16'($sampled(s2.wr_en)));
    a_wr_reg: assert property (@(posedge clk) disable iff (!arst_n)
        !s2.wr_en || wr_reg == s2.wr_reg)
        else value_error("wr_reg", 16'($sampled(wr_reg)), 16'($sampled(s2.wr_reg)));
    a_wr_data: assert property (@(posedge clk) disable iff (!arst_n)
        !s2.wr_en || wr_data == s2.wr_data)
        else value_error("wr_data", $sampled(wr_data), $sampled(s2.wr_data));
    a_mem_en: assert property (@(posedge clk) disable iff (!arst_n) mem_en == s2.mem_en)
        else value_error("mem_en", 16'($sampled(mem_en)), 16'($sampled(s2.mem_en)));
    a_mem_wr: assert property (@(posedge clk) disable iff (!arst_n) mem_wr == s2.mem_wr)
        else value_error("mem_wr", 16'($sampled(mem_wr)), 16'($sampled(s2.mem_wr)));
    a_mem_addr: assert property (@(posedge clk) disable iff (!arst_n)
        !s2.mem_en || mem_addr == s2.mem_addr)
        else value_error("mem_addr", $sampled(mem_addr), $sampled(s2.mem_addr));
    a_mem_wdata: assert property (@(posedge clk) disable iff (!arst_n)
        !s2.mem_wr || mem_wdata == s2.mem_wdata)
        else value_error("mem_wdata", $sampled(mem_wdata), $sampled(s2.mem_wdata));
    a_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        redirect == s2.redirect)
        else value_error("redirect", 16'($sampled(redirect)), 16'($sampled(s2.redirect)));
    a_redirect_pc: assert property (@(posedge clk) disable iff (!arst_n)
        !s2.redirect || redirect_pc == s2.redirect_pc)
        else value_error("redirect_pc", $sampled(redirect_pc), $sampled(s2.redirect_pc));
    a_halted: assert property (@(posedge clk) disable iff (!arst_n) halted == s2.halted)
        else value_error("halted", 16'($sampled(halted)), 16'($sampled(s2.halted)));

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic isa_pkg::data_t enc_r(input logic [4:0] opc, input logic [2:0] rs,
                                             input logic [2:0] rt, input logic [2:0] rd);
        return {opc, rs, rt, rd, 2'b00};
    endfunction

    function automatic isa_pkg::data_t enc_i(input logic [4:0] opc, input logic [2:0] rs,
                                             input logic [2:0] rt, input logic [4:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // ISA rules applied to the reference register file
    task automatic predict(input isa_pkg::data_t ins, output expect_t e);
        logic [4:0]     opc;
        isa_pkg::data_t a;
        isa_pkg::data_t b;
        isa_pkg::data_t i5;
        isa_pkg::data_t i8;
        opc = ins[15:11];
        a   = ref_regs[ins[10:8]];
        b   = ref_regs[ins[7:5]];
        i5  = {{11{ins[4]}}, ins[4:0]};
        i8  = {{8{ins[7]}}, ins[7:0]};
        e   = '0;
        e.wr_reg = ins[4:2];
        case (opc)
            isa_pkg::OPC_ADD: e.wr_data = a + b;
            isa_pkg::OPC_SUB: e.wr_data = a - b;
            isa_pkg::OPC_AND: e.wr_data = a & b;
            isa_pkg::OPC_XOR: e.wr_data = a ^ b;
            isa_pkg::OPC_SLT: e.wr_data = {15'd0, $signed(a) < $signed(b)};
            isa_pkg::OPC_SEQ: e.wr_data = {15'd0, a == b};
            isa_pkg::OPC_ADDI: begin
                e.wr_data = a + i5;
                e.wr_reg  = ins[7:5];
            end
            isa_pkg::OPC_LD, isa_pkg::OPC_ST: begin
                e.mem_en    = 1'b1;
                e.mem_wr    = (opc == isa_pkg::OPC_ST);
                e.mem_addr  = a + i5;
                e.mem_wdata = b;
            end
            isa_pkg::OPC_BEQZ, isa_pkg::OPC_BNEZ: begin
                e.redirect    = (opc == isa_pkg::OPC_BEQZ) ? (a == 16'd0) : (a != 16'd0);
                e.redirect_pc = pc_inc + i8;
            end
            isa_pkg::OPC_JR: begin
                e.redirect    = 1'b1;
                e.redirect_pc = a;
            end
            isa_pkg::OPC_HALT: model_halted = 1'b1;
            default: ;
        endcase
        e.wr_en = opc[4:3] == 2'b11 || opc == isa_pkg::OPC_ADDI;
        if (e.wr_en) ref_regs[e.wr_reg] = e.wr_data;
        flush_pend = e.redirect;
    endtask

    // one decode cycle entered and left 0.5 ns after a rising edge
    task automatic step(input isa_pkg::data_t ins, input logic valid, input logic stall);
        expect_t e;
        logic    go;
        e  = '0;
        go = valid && stall && !flush_pend && !model_halted;
        flush_pend = 1'b0;
        if (go) predict(ins, e);
        e.halted    = model_halted;
        instr       = ins;
        instr_valid = valid;
        stall_n     = stall;
        cur         = e;
        @(posedge clk);
        #0.5;
        pc_inc = pc_inc + 16'd1;
    endtask

    task automatic nop();
        step(enc_r(isa_pkg::OPC_NOP, 3'd0, 3'd0, 3'd0), 1'b1, 1'b1);
    endtask

    task automatic issue(input isa_pkg::data_t ins);
        step(ins, 1'b1, 1'b1);
        nop();                       // no forwarding so keep dependents apart
        nop();
    endtask

    task automatic load_reg(input logic [2:0] r, input isa_pkg::data_t v);
        issue(enc_i(isa_pkg::OPC_ADDI, 3'd0, r, {1'b0, v[15:12]}));
        for (int k = 2; k >= 0; k--) begin
            repeat (4) issue(enc_r(isa_pkg::OPC_ADD, r, r, r));  // shift left
            issue(enc_i(isa_pkg::OPC_ADDI, r, r, {1'b0, v[k*4 +: 4]}));
        end
    endtask

    task automatic finish_test(input string name);
        repeat (3) nop();
        if (err_cnt == err_mark) pass_cnt++;
        else fail_cnt++;
        $display("test %-8s: %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [4:0] opc;
        logic [4:0] ops [7];
        ops = '{isa_pkg::OPC_ADD, isa_pkg::OPC_SUB, isa_pkg::OPC_AND, isa_pkg::OPC_XOR,
                isa_pkg::OPC_ADDI, isa_pkg::OPC_SLT, isa_pkg::OPC_SEQ};
        instr = '0;
        instr_valid = 1'b0;
        pc_inc = 16'h0100;
        stall_n = 1'b1;
        cur = '0;
        flush_pend = 1'b0;
        model_halted = 1'b0;
        rng = 32'd51;
        err_cnt = 0;
        err_mark = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int i = 0; i < 8; i++) ref_regs[i] = '0;

        @(posedge clk);
        assert (!wr_en && !mem_en && !mem_wr && !redirect && !halted) else begin
            value_error("{wr_en,mem_en,mem_wr,redirect,halted}",
                        16'({wr_en, mem_en, mem_wr, redirect, halted}), 16'h0000);
        end
        wait (arst_n);
        for (int i = 0; i < 8; i++) issue(enc_r(isa_pkg::OPC_SUB, 3'(i), 3'd0, 3'(i)));
        finish_test("reset");

        for (int i = 1; i < 8; i++) load_reg(3'(i), 16'(next_rand())); // r0 stays zero
        for (int i = 0; i < N_RAND; i++) begin
            opc = ops[3'(next_rand() % 7)];
            rs  = 3'(next_rand());
            rt  = 3'(next_rand());
            rd  = 3'(1 + next_rand() % 7);
            if (opc == isa_pkg::OPC_ADDI) issue(enc_i(opc, rs, rd, 5'(next_rand())));
            else issue(enc_r(opc, rs, rt, rd));
        end
        finish_test("alu");

        for (int i = 0; i < N_MEM; i++) begin
            opc = next_rand() % 2 ? isa_pkg::OPC_ST : isa_pkg::OPC_LD;
            issue(enc_i(opc, 3'(next_rand()), 3'(next_rand()), 5'(next_rand())));
        end
        finish_test("memory");

        step(enc_i(isa_pkg::OPC_ADDI, 3'd0, 3'd4, 5'd7), 1'b1, 1'b0);
        step(enc_i(isa_pkg::OPC_ADDI, 3'd0, 3'd5, 5'd9), 1'b0, 1'b1);
        issue(enc_i(isa_pkg::OPC_ADDI, 3'd0, 3'd4, 5'd7)); // re-presented
        issue(enc_r(isa_pkg::OPC_ADD, 3'd4, 3'd5, 3'd6));
        step(enc_i(isa_pkg::OPC_ST, 3'd4, 3'd6, 5'd2), 1'b1, 1'b0);
        issue(enc_i(isa_pkg::OPC_ST, 3'd4, 3'd6, 5'd2));   // re-presented
        finish_test("stall");

        issue(enc_i(isa_pkg::OPC_ADDI, 3'd0, 3'd1, 5'd5));
        step({isa_pkg::OPC_BEQZ, 3'd0, 8'hf4}, 1'b1, 1'b1);          // taken
        issue(enc_i(isa_pkg::OPC_ADDI, 3'd1, 3'd1, 5'd3));            // flushed
        step({isa_pkg::OPC_BNEZ, 3'd1, 8'h22}, 1'b1, 1'b1);          // taken
        issue(enc_i(isa_pkg::OPC_ADDI, 3'd1, 3'd2, 5'd1));            // flushed
        step({isa_pkg::OPC_BNEZ, 3'd0, 8'h10}, 1'b1, 1'b1);          // not taken
        issue(enc_i(isa_pkg::OPC_ADDI, 3'd2, 3'd2, 5'd3));
        step({isa_pkg::OPC_BEQZ, 3'd1, 8'h80}, 1'b1, 1'b1);          // not taken
        issue(enc_i(isa_pkg::OPC_ADDI, 3'd3, 3'd3, 5'd2));
        step(enc_r(isa_pkg::OPC_JR, 3'd7, 3'd0, 3'd0), 1'b1, 1'b1);
        issue(enc_r(isa_pkg::OPC_ADD, 3'd1, 3'd1, 3'd1));             // flushed
        issue(enc_r(isa_pkg::OPC_XOR, 3'd1, 3'd2, 3'd3));
        finish_test("branch");

        step(enc_r(isa_pkg::OPC_HALT, 3'd0, 3'd0, 3'd0), 1'b1, 1'b1);
        issue(enc_i(isa_pkg::OPC_ADDI, 3'd0, 3'd3, 5'd4));
        issue(enc_r(isa_pkg::OPC_ADD, 3'd1, 3'd2, 3'd5));
        issue(enc_i(isa_pkg::OPC_ST, 3'd1, 3'd2, 5'd1));
        finish_test("halt");

        $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
instr_decode.sv
id_ex.sv
execute.sv
result_stage.sv
exec_core.sv
tb_clk_gen.sv
tb_exec_core.sv

// File: Makefile
TOP = tb_exec_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
